/* verilog/dcache_consts.svh */
// Cache geometry, refill line size and SPR address defines
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Operand and address width
`define DC_WORD_WIDTH 32
// Byte offset bits of a 32-byte line
`define DC_BLOCK_WIDTH 5
// 16 sets
`define DC_SET_WIDTH 4
`define DC_WAYS 2
// Cacheable address range
`define DC_LIMIT_WIDTH 32

// Bytes covered by one way, set plus offset
`define DC_WAY_WIDTH (`DC_BLOCK_WIDTH + `DC_SET_WIDTH)
// Address bits left of the set index
`define DC_TAG_WIDTH (`DC_LIMIT_WIDTH - `DC_WAY_WIDTH)

// Words per line, filled one strobe each
`define DC_LINE_WORDS 8
// One history bit per pair of ways
`define DC_LRU_WIDTH ((`DC_WAYS * (`DC_WAYS - 1)) / 2)

// Block flush and block invalidate registers
`define DC_SPR_DCBFR_ADDR 16'h3002
`define DC_SPR_DCBIR_ADDR 16'h3003

`endif

/* verilog/dcache_pkg.sv */
// Width typedefs and controller state encoding of the data cache
`include "dcache_consts.svh"

package dcache_pkg;

  // Data word or byte address
  typedef logic [`DC_WORD_WIDTH-1:0] word_t;
  // Address bits above the set index
  typedef logic [`DC_TAG_WIDTH-1:0] tag_t;
  // Valid bit sits above the tag
  typedef logic [`DC_TAG_WIDTH:0] tag_entry_t;
  typedef logic [`DC_SET_WIDTH-1:0] set_idx_t;
  // Word within a line
  typedef logic [`DC_BLOCK_WIDTH-3:0] word_idx_t;
  // Way RAM address, set and word together
  typedef logic [`DC_WAY_WIDTH-3:0] way_addr_t;
  // One bit per way, one-hot or flags
  typedef logic [`DC_WAYS-1:0] ways_t;
  typedef logic [`DC_LRU_WIDTH-1:0] lru_hist_t;
  // Byte enables of a word
  typedef logic [3:0] bsel_t;

  //////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    IDLE,
    READ,
    WRITE,
    REFILL,
    INVALIDATE
  } cache_state_e;

endpackage

/* verilog/dcache_if.sv */
// Tag port and way RAM port interfaces of the data cache
`timescale 1ns/1ps
`include "dcache_consts.svh"

// Tag memory access between controller and tag store
interface tag_port_if;
  dcache_pkg::set_idx_t   rindex;
  dcache_pkg::set_idx_t   windex;
  logic                   we;
  dcache_pkg::tag_entry_t way_in [`DC_WAYS];
  dcache_pkg::lru_hist_t  lru_in;
  // One-hot way used this cycle
  dcache_pkg::ways_t      access;
  dcache_pkg::tag_entry_t way_out [`DC_WAYS];
  dcache_pkg::ways_t      way_hit;
  // Victim before the access, one-hot
  dcache_pkg::ways_t      lru;
  // History after the access
  dcache_pkg::lru_hist_t  next_lru;

  modport ctrl (
    output rindex, windex, we, way_in, lru_in, access,
    input  way_out, way_hit, lru, next_lru
  );

  modport store (
    input  rindex, windex, we, way_in, lru_in, access,
    output way_out, way_hit, lru, next_lru
  );
endinterface

// One way's data RAM, read data one cycle after raddr
interface way_port_if;
  dcache_pkg::way_addr_t raddr;
  dcache_pkg::way_addr_t waddr;
  logic                  we;
  dcache_pkg::word_t     din;
  dcache_pkg::word_t     dout;

  modport ctrl (output raddr, waddr, we, din, input dout);
endinterface

/* verilog/dcache_dpram.sv */
// Dual-port RAM with one registered read port and one write port
`timescale 1ns/1ps

module dcache_dpram #(
  parameter int ADDR_WIDTH = 7,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic [ADDR_WIDTH-1:0] raddr_i,
  input  logic [ADDR_WIDTH-1:0] waddr_i,
  input  logic [DATA_WIDTH-1:0] din_i,
  input  logic                  we_i,
  output logic [DATA_WIDTH-1:0] dout_o
);

  localparam int DEPTH = 1 << ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // All entries start cleared, so tag valid bits read as zero
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // Read and write are independent
  // a read of the word being written sees the old contents
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
    dout_o <= mem[raddr_i];
  end

endmodule

/* verilog/dcache_lru.sv */
// Matrix pseudo-LRU: history update and one-hot victim selection
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_lru (
  input  dcache_pkg::lru_hist_t current_i,
  input  dcache_pkg::ways_t     access_i,
  output dcache_pkg::lru_hist_t update_o,
  output dcache_pkg::ways_t     lru_pre_o
);

  // Age matrix: bit [i][j] set means way i was used before way j.
  // Only the upper triangle is stored, the lower one is its inverse.
  always_comb begin
    logic [`DC_WAYS-1:0] age [`DC_WAYS];
    int off;

    off = 0;
    // Expand the stored history into the full matrix
    for (int i = 0; i < `DC_WAYS; i++) begin
      age[i][i] = 1'b1;
      for (int j = i + 1; j < `DC_WAYS; j++) begin
        age[i][j] = current_i[off + j - i - 1];
      end
      for (int j = 0; j < i; j++) begin
        age[i][j] = ~age[j][i];
      end
      off = off + `DC_WAYS - i - 1;
    end

    // Victim is the way older than every other one
    for (int i = 0; i < `DC_WAYS; i++) begin
      lru_pre_o[i] = &age[i];
    end

    // Accessed way becomes younger than all others
    for (int i = 0; i < `DC_WAYS; i++) begin
      if (access_i[i]) begin
        for (int j = 0; j < `DC_WAYS; j++) begin
          if (j != i) begin
            age[i][j] = 1'b0;
            age[j][i] = 1'b1;
          end
        end
      end
    end

    // Fold the upper triangle back into history bits
    off = 0;
    for (int i = 0; i < `DC_WAYS; i++) begin
      for (int j = i + 1; j < `DC_WAYS; j++) begin
        update_o[off + j - i - 1] = age[i][j];
      end
      off = off + `DC_WAYS - i - 1;
    end
  end

endmodule

/* verilog/dcache_tag_store.sv */
// Tag RAM with entry packing, per-way tag compare and LRU tracking
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tag_store (
  input  logic              clk,
  input  logic              rst,
  tag_port_if.store         tag,
  input  dcache_pkg::tag_t  match_tag_i
);

  localparam int ENTRY_W = $bits(dcache_pkg::tag_entry_t);
  localparam int LRU_W   = `DC_LRU_WIDTH;
  // LRU history on top, way N-1 down to way 0 below it
  localparam int RAM_W   = ENTRY_W * `DC_WAYS + LRU_W;

  logic [RAM_W-1:0]      ram_din;
  logic [RAM_W-1:0]      ram_dout;
  dcache_pkg::lru_hist_t hist;
  // Set once a lookup has been clocked outside reset
  logic                  rd_valid;

  //////////////////////////////////////////////////////////////
  // Entry packing and tag compare
  //////////////////////////////////////////////////////////////
  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    assign ram_din[w*ENTRY_W +: ENTRY_W] = tag.way_in[w];
    assign tag.way_out[w] = ram_dout[w*ENTRY_W +: ENTRY_W];

    // Hit needs the valid bit and an equal tag
    assign tag.way_hit[w] = rd_valid & tag.way_out[w][`DC_TAG_WIDTH] &
                            (tag.way_out[w][`DC_TAG_WIDTH-1:0] == match_tag_i);
  end

  assign ram_din[RAM_W-1 -: LRU_W] = tag.lru_in;
  assign hist = ram_dout[RAM_W-1 -: LRU_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // Tag RAM and replacement state
  //////////////////////////////////////////////////////////////
  // One read per cycle, the index leads the data by a cycle
  dcache_dpram #(
    .ADDR_WIDTH (`DC_SET_WIDTH),
    .DATA_WIDTH (RAM_W)
  ) u_tag_ram (
    .clk     (clk),
    .raddr_i (tag.rindex),
    .waddr_i (tag.windex),
    .din_i   (ram_din),
    .we_i    (tag.we),
    .dout_o  (ram_dout)
  );

  // History from the read set, updated for this cycle's access
  dcache_lru u_lru (
    .current_i (hist),
    .access_i  (tag.access),
    .update_o  (tag.next_lru),
    .lru_pre_o (tag.lru)
  );

endmodule

/* verilog/dcache_ctrl.sv */
// Data cache controller: FSM, refill tracking, tag-write composition and byte merge
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
  input  logic              clk,
  input  logic              rst,
  // CPU side
  input  dcache_pkg::word_t cpu_adr_i,
  input  dcache_pkg::word_t cpu_adr_match_i,
  input  logic              cpu_req_i,
  input  logic              cpu_we_i,
  input  dcache_pkg::word_t cpu_dat_i,
  input  dcache_pkg::bsel_t cpu_bsel_i,
  output logic              cpu_ack_o,
  // Refill side
  output logic              refill_req_o,
  output logic              refill_o,
  output logic              refill_done_o,
  input  dcache_pkg::word_t wradr_i,
  input  dcache_pkg::word_t wrdat_i,
  input  logic              we_i,
  input  logic              dbus_err_i,
  // SPR side
  input  logic [15:0]       spr_bus_addr_i,
  input  logic              spr_bus_we_i,
  input  logic              spr_bus_stb_i,
  input  dcache_pkg::word_t spr_bus_dat_i,
  output logic              spr_bus_ack_o,
  // Tag store and way RAMs
  tag_port_if.ctrl          tag,
  way_port_if.ctrl          way [`DC_WAYS],
  output dcache_pkg::ways_t way_sel_o,
  input  dcache_pkg::word_t hit_data_i
);

  dcache_pkg::cache_state_e state;
  logic st_idle, st_read, st_write, st_refill, st_inval;
  logic hit;
  logic invalidate;
  // Upcoming write seen while busy
  logic write_pending;

  dcache_pkg::tag_t       match_tag;
  dcache_pkg::set_idx_t   match_set;
  dcache_pkg::word_idx_t  match_word;
  dcache_pkg::word_idx_t  refill_word;
  logic [`DC_LINE_WORDS-1:0] word_bit;
  // Words already written into the victim, and a copy one cycle late
  logic [`DC_LINE_WORDS-1:0] refill_valid;
  logic [`DC_LINE_WORDS-1:0] refill_valid_r;
  logic refill_done;
  logic refill_hit;

  // Captured at the miss
  dcache_pkg::ways_t      victim;
  dcache_pkg::tag_entry_t way_save [`DC_WAYS];
  dcache_pkg::tag_t       refill_tag;
  dcache_pkg::set_idx_t   refill_set;
  dcache_pkg::set_idx_t   inv_idx;

  dcache_pkg::ways_t way_we;
  dcache_pkg::word_t way_wr_dat;

  assign st_idle   = (state == dcache_pkg::IDLE);
  assign st_read   = (state == dcache_pkg::READ);
  assign st_write  = (state == dcache_pkg::WRITE);
  assign st_refill = (state == dcache_pkg::REFILL);
  assign st_inval  = (state == dcache_pkg::INVALIDATE);

  assign hit        = |tag.way_hit;
  assign match_tag  = cpu_adr_match_i[`DC_LIMIT_WIDTH-1:`DC_WAY_WIDTH];
  assign match_set  = cpu_adr_match_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
  assign match_word = cpu_adr_match_i[`DC_BLOCK_WIDTH-1:2];

  // Block flush and block invalidate do the same here
  assign invalidate = spr_bus_stb_i & spr_bus_we_i &
                      (spr_bus_addr_i == `DC_SPR_DCBFR_ADDR |
                       spr_bus_addr_i == `DC_SPR_DCBIR_ADDR);
  assign spr_bus_ack_o = spr_bus_stb_i & (st_idle | st_inval);

  //////////////////////////////////////////////////////////////
  // Refill bookkeeping
  //////////////////////////////////////////////////////////////
  assign refill_word = wradr_i[`DC_BLOCK_WIDTH-1:2];
  assign word_bit    = {{(`DC_LINE_WORDS-1){1'b0}}, 1'b1} << refill_word;

  // Words may come in any order, done when this strobe fills the last gap
  assign refill_done = st_refill & we_i & (&(refill_valid | word_bit));

  // Requested word of the refilled line already sits in the way RAM
  assign refill_hit = st_refill & !write_pending & refill_valid_r[match_word] &
                      (match_tag == refill_tag) & (match_set == refill_set);

  assign cpu_ack_o = cpu_req_i &
                     ((st_read & hit & !write_pending) | st_write | refill_hit);
  assign refill_req_o  = st_read & cpu_req_i & !hit & !write_pending;
  assign refill_o      = st_refill;
  assign refill_done_o = refill_done;

  // Refilling line is the victim, otherwise the hitting way
  assign way_sel_o = st_refill ? victim : tag.way_hit;

  //////////////////////////////////////////////////////////////
  // Way RAM ports
  //////////////////////////////////////////////////////////////
  // Keep stored bytes where the byte enable is low
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      way_wr_dat[8*b +: 8] = cpu_bsel_i[b] ? cpu_dat_i[8*b +: 8] : hit_data_i[8*b +: 8];
    end
  end

  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
    assign way[w].raddr = cpu_adr_i[`DC_WAY_WIDTH-1:2];
    assign way[w].waddr = st_write ? cpu_adr_match_i[`DC_WAY_WIDTH-1:2]
                                   : wradr_i[`DC_WAY_WIDTH-1:2];
    assign way[w].din   = st_write ? way_wr_dat : wrdat_i;
    assign way[w].we    = way_we[w];
  end

  // Refill keeps reading its own set, otherwise look up the next address
  assign tag.rindex = st_refill ? refill_set : cpu_adr_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];

  //////////////////////////////////////////////////////////////
  // Tag write composition
  //////////////////////////////////////////////////////////////
  always_comb begin
    tag.we     = 1'b0;
    tag.windex = match_set;
    tag.access = '0;
    tag.lru_in = tag.next_lru;
    way_we     = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      tag.way_in[w] = tag.way_out[w];
    end

    case (state)
      dcache_pkg::READ: begin
        // Hit only moves the LRU history
        if (hit & cpu_req_i) begin
          tag.access = tag.way_hit;
          tag.we     = 1'b1;
        end
      end
      dcache_pkg::WRITE: begin
        // Write miss leaves everything untouched
        if (hit & cpu_req_i) begin
          tag.access = tag.way_hit;
          way_we     = tag.way_hit;
          tag.we     = 1'b1;
        end
      end
      dcache_pkg::REFILL: begin
        tag.windex = refill_set;
        if (we_i) begin
          way_we     = victim;
          tag.access = victim;
          for (int w = 0; w < `DC_WAYS; w++) begin
            tag.way_in[w] = way_save[w];
          end
          // Victim goes invalid with the first word
          if (refill_valid == '0) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
              if (victim[w]) tag.way_in[w][`DC_TAG_WIDTH] = 1'b0;
            end
            tag.we = 1'b1;
          end
          // Last word makes the new line valid
          if (refill_done) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
              if (victim[w]) tag.way_in[w] = {1'b1, refill_tag};
            end
            tag.we = 1'b1;
          end
        end
      end
      dcache_pkg::INVALIDATE: begin
        // Whole set is cleared, whatever the tag
        tag.windex = inv_idx;
        tag.lru_in = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
          tag.way_in[w] = '0;
        end
        tag.we = 1'b1;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////
  // cpu_we_i comes with cpu_adr_i and lasts one cycle,
  // so it is held in write_pending until the write state takes it
  always_ff @(posedge clk) begin
    if (rst | dbus_err_i) begin
      state         <= dcache_pkg::IDLE;
      write_pending <= 1'b0;
      if (rst) begin
        refill_valid   <= '0;
        refill_valid_r <= '0;
      end
    end else begin
      if (cpu_we_i) begin
        write_pending <= 1'b1;
      end else if (!cpu_req_i) begin
        write_pending <= 1'b0;
      end
      refill_valid_r <= refill_valid;

      case (state)
        dcache_pkg::IDLE: begin
          if (invalidate) state <= dcache_pkg::INVALIDATE;
          else if (cpu_we_i | write_pending) state <= dcache_pkg::WRITE;
          else if (cpu_req_i) state <= dcache_pkg::READ;
        end
        dcache_pkg::READ: begin
          if (refill_req_o) begin
            refill_valid   <= '0;
            refill_valid_r <= '0;
            state          <= dcache_pkg::REFILL;
          end else if (cpu_we_i | write_pending) begin
            state <= dcache_pkg::WRITE;
          end else if (invalidate) begin
            state <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::REFILL: begin
          if (we_i) begin
            refill_valid <= refill_valid | word_bit;
            if (refill_done) state <= dcache_pkg::IDLE;
          end
        end
        dcache_pkg::WRITE: begin
          // Back-to-back writes stay here
          if (!cpu_req_i | !cpu_we_i) begin
            write_pending <= 1'b0;
            state         <= dcache_pkg::READ;
          end
        end
        dcache_pkg::INVALIDATE: begin
          if (!invalidate) state <= dcache_pkg::IDLE;
        end
        default: state <= dcache_pkg::IDLE;
      endcase
    end
  end

  // Miss context and invalidate index
  always_ff @(posedge clk) begin
    if (refill_req_o) begin
      victim     <= tag.lru;
      way_save   <= tag.way_out;
      refill_tag <= match_tag;
      refill_set <= match_set;
    end
    if (invalidate & (st_idle | st_inval)) begin
      inv_idx <= spr_bus_dat_i[`DC_WAY_WIDTH-1:`DC_BLOCK_WIDTH];
    end
  end

endmodule

/* verilog/dcache_top.sv */
// Data cache top level: controller, tag store, way RAMs and read-data mux
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
  input  logic              clk,
  input  logic              rst,
  // CPU side
  input  dcache_pkg::word_t cpu_adr_i,
  input  dcache_pkg::word_t cpu_adr_match_i,
  input  logic              cpu_req_i,
  input  logic              cpu_we_i,
  input  dcache_pkg::word_t cpu_dat_i,
  input  dcache_pkg::bsel_t cpu_bsel_i,
  output logic              cpu_ack_o,
  output dcache_pkg::word_t cpu_dat_o,
  // Refill side
  output logic              refill_req_o,
  output logic              refill_o,
  output logic              refill_done_o,
  input  dcache_pkg::word_t wradr_i,
  input  dcache_pkg::word_t wrdat_i,
  input  logic              we_i,
  input  logic              dbus_err_i,
  // SPR side
  input  logic [15:0]       spr_bus_addr_i,
  input  logic              spr_bus_we_i,
  input  logic              spr_bus_stb_i,
  input  dcache_pkg::word_t spr_bus_dat_i,
  output logic              spr_bus_ack_o
);

  tag_port_if u_tag_if ();
  way_port_if u_way_if [`DC_WAYS] ();

  dcache_pkg::ways_t way_sel;
  dcache_pkg::word_t way_dout [`DC_WAYS];

  dcache_ctrl u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .cpu_adr_i       (cpu_adr_i),
    .cpu_adr_match_i (cpu_adr_match_i),
    .cpu_req_i       (cpu_req_i),
    .cpu_we_i        (cpu_we_i),
    .cpu_dat_i       (cpu_dat_i),
    .cpu_bsel_i      (cpu_bsel_i),
    .cpu_ack_o       (cpu_ack_o),
    .refill_req_o    (refill_req_o),
    .refill_o        (refill_o),
    .refill_done_o   (refill_done_o),
    .wradr_i         (wradr_i),
    .wrdat_i         (wrdat_i),
    .we_i            (we_i),
    .dbus_err_i      (dbus_err_i),
    .spr_bus_addr_i  (spr_bus_addr_i),
    .spr_bus_we_i    (spr_bus_we_i),
    .spr_bus_stb_i   (spr_bus_stb_i),
    .spr_bus_dat_i   (spr_bus_dat_i),
    .spr_bus_ack_o   (spr_bus_ack_o),
    .tag             (u_tag_if),
    .way             (u_way_if),
    .way_sel_o       (way_sel),
    // Stored word feeds the byte merge of a write hit
    .hit_data_i      (cpu_dat_o)
  );

  dcache_tag_store u_tag_store (
    .clk         (clk),
    .rst         (rst),
    .tag         (u_tag_if),
    .match_tag_i (cpu_adr_match_i[`DC_LIMIT_WIDTH-1:`DC_WAY_WIDTH])
  );

  //////////////////////////////////////////////////////////////
  // Way data RAMs
  //////////////////////////////////////////////////////////////
  for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way_ram
    dcache_dpram #(
      .ADDR_WIDTH (`DC_WAY_WIDTH - 2),
      .DATA_WIDTH (`DC_WORD_WIDTH)
    ) u_way_ram (
      .clk     (clk),
      .raddr_i (u_way_if[w].raddr),
      .waddr_i (u_way_if[w].waddr),
      .din_i   (u_way_if[w].din),
      .we_i    (u_way_if[w].we),
      .dout_o  (u_way_if[w].dout)
    );
    assign way_dout[w] = u_way_if[w].dout;
  end

  // Selected way onto the CPU data port, zero when none is selected
  always_comb begin
    cpu_dat_o = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (way_sel[w]) cpu_dat_o = way_dout[w];
    end
  end

endmodule

/* test/tb_dcache.sv */
// Data cache testbench with clock, reset, refill memory model, stimulus tasks, assertions and timeout
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache;

  // Reads, writes and SPR strobes across all tests with margin
  localparam int NUM_ACCESSES      = 30;
  // Worst case per access is a full line refill plus lookup
  localparam int CYCLES_PER_ACCESS = 20;
  localparam int TIMEOUT_CYCLES    = NUM_ACCESSES * CYCLES_PER_ACCESS * 5;

  // Line L sits in set 0 and lines A, B and C share set 2
  localparam dcache_pkg::word_t LINE_L = 32'h0000_2000;
  localparam dcache_pkg::word_t LINE_A = 32'h0000_1040;
  localparam dcache_pkg::word_t LINE_B = 32'h0000_1240;
  localparam dcache_pkg::word_t LINE_C = 32'h0000_1440;

  logic              clk = 1'b0;
  logic              rst;
  dcache_pkg::word_t cpu_adr_i;
  dcache_pkg::word_t cpu_adr_match_i;
  logic              cpu_req_i;
  logic              cpu_we_i;
  dcache_pkg::word_t cpu_dat_i;
  dcache_pkg::bsel_t cpu_bsel_i;
  logic              cpu_ack_o;
  dcache_pkg::word_t cpu_dat_o;
  logic              refill_req_o;
  logic              refill_o;
  logic              refill_done_o;
  dcache_pkg::word_t wradr_i;
  dcache_pkg::word_t wrdat_i;
  logic              we_i;
  logic              dbus_err_i;
  logic [15:0]       spr_bus_addr_i;
  logic              spr_bus_we_i;
  logic              spr_bus_stb_i;
  dcache_pkg::word_t spr_bus_dat_i;
  logic              spr_bus_ack_o;

  integer            seed;
  dcache_pkg::word_t key;
  bit                failed = 1'b0;
  int                cycle_count = 0;
  // High with the strobe that carries the last word of a line
  bit                last_word = 1'b0;
  // Words changed by CPU writes
  // All other words follow address XOR key
  dcache_pkg::word_t written [dcache_pkg::word_t];

  always #5 clk = ~clk;

  dcache_top u_dcache_top (
    .clk             (clk),
    .rst             (rst),
    .cpu_adr_i       (cpu_adr_i),
    .cpu_adr_match_i (cpu_adr_match_i),
    .cpu_req_i       (cpu_req_i),
    .cpu_we_i        (cpu_we_i),
    .cpu_dat_i       (cpu_dat_i),
    .cpu_bsel_i      (cpu_bsel_i),
    .cpu_ack_o       (cpu_ack_o),
    .cpu_dat_o       (cpu_dat_o),
    .refill_req_o    (refill_req_o),
    .refill_o        (refill_o),
    .refill_done_o   (refill_done_o),
    .wradr_i         (wradr_i),
    .wrdat_i         (wrdat_i),
    .we_i            (we_i),
    .dbus_err_i      (dbus_err_i),
    .spr_bus_addr_i  (spr_bus_addr_i),
    .spr_bus_we_i    (spr_bus_we_i),
    .spr_bus_stb_i   (spr_bus_stb_i),
    .spr_bus_dat_i   (spr_bus_dat_i),
    .spr_bus_ack_o   (spr_bus_ack_o)
  );

  ////////////////////////////////////////////////////////////
  // Error handling and memory model
  ////////////////////////////////////////////////////////////
  task automatic report_error(input string line);
    failed = 1'b1;
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  function automatic dcache_pkg::word_t model_word(input dcache_pkg::word_t addr);
    if (written.exists(addr)) begin
      return written[addr];
    end
    return addr ^ key;
  endfunction

  // Answers a refill request with the whole line in order and one word per cycle
  always begin : refill_model
    dcache_pkg::word_t base;
    @(negedge clk);
    if (refill_req_o) begin
      base = {cpu_adr_match_i[`DC_WORD_WIDTH-1:`DC_BLOCK_WIDTH], {`DC_BLOCK_WIDTH{1'b0}}};
      for (int i = 0; i < `DC_LINE_WORDS; i++) begin
        @(posedge clk);
        we_i      <= 1'b1;
        wradr_i   <= base + 4 * i;
        wrdat_i   <= model_word(base + 4 * i);
        last_word <= (i == `DC_LINE_WORDS - 1);
      end
      @(posedge clk);
      we_i      <= 1'b0;
      last_word <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      report_error($sformatf("Timeout: the run did not finish within %0d cycles",
                             TIMEOUT_CYCLES));
    end
  end

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////
  task automatic check_idle_outputs(input string where);
    assert (!cpu_ack_o && !refill_req_o && !refill_o && !refill_done_o && !spr_bus_ack_o)
      else report_error($sformatf("CHECK FAILED at %0t: control output high in %s",
                                  $time, where));
  endtask

  always @(negedge clk) begin
    if (rst) begin
      check_idle_outputs("reset");
    end
  end

  // The last strobe of a line completes it and no other cycle does
  done_on_last_word: assert property (@(posedge clk) disable iff (rst)
    refill_done_o == (we_i && last_word))
    else report_error($sformatf("CHECK FAILED at %0t: refill_done_o not on the last strobe",
                                $time));

  // Every word of the line arrives while refilling
  strobe_in_refill: assert property (@(posedge clk) disable iff (rst)
    we_i |-> refill_o)
    else report_error($sformatf("CHECK FAILED at %0t: refill strobe outside refill", $time));

  // Miss moves on to refill
  miss_enters_refill: assert property (@(posedge clk) disable iff (rst)
    refill_req_o |=> refill_o)
    else report_error($sformatf("CHECK FAILED at %0t: no refill after refill_req_o", $time));

  // Completed line returns to idle
  done_leaves_refill: assert property (@(posedge clk) disable iff (rst)
    refill_done_o |=> !refill_o)
    else report_error($sformatf("CHECK FAILED at %0t: refill_o high after refill_done_o",
                                $time));

  ////////////////////////////////////////////////////////////
  // CPU and SPR stimulus
  ////////////////////////////////////////////////////////////
  // Lookup address first and the match address with the request a cycle later
  task automatic read_word(input dcache_pkg::word_t addr, output dcache_pkg::word_t data,
                           output bit refilled);
    refilled = 1'b0;
    @(posedge clk);
    cpu_adr_i <= addr;
    cpu_req_i <= 1'b0;
    @(posedge clk);
    cpu_adr_match_i <= addr;
    cpu_req_i       <= 1'b1;
    do begin
      @(negedge clk);
      if (refill_req_o) refilled = 1'b1;
    end while (!cpu_ack_o);
    data = cpu_dat_o;
    @(posedge clk);
    cpu_req_i <= 1'b0;
    // An early ack can come while the rest of the line still streams in
    @(negedge clk);
    while (refill_o) @(negedge clk);
  endtask

  task automatic read_and_compare(input dcache_pkg::word_t addr, input bit expect_refill);
    dcache_pkg::word_t data;
    bit                refilled;
    read_word(addr, data, refilled);
    assert (data == model_word(addr))
      else report_error($sformatf("CHECK FAILED at %0t: read 0x%08h gave 0x%08h, expected 0x%08h",
                                  $time, addr, data, model_word(addr)));
    assert (refilled == expect_refill)
      else report_error($sformatf("CHECK FAILED at %0t: read 0x%08h refill request %0b, expected %0b",
                                  $time, addr, refilled, expect_refill));
  endtask

  // cpu_we_i is a one-cycle pulse that travels with the lookup address
  task automatic write_bytes(input dcache_pkg::word_t addr, input dcache_pkg::word_t data,
                             input dcache_pkg::bsel_t bsel);
    @(posedge clk);
    cpu_adr_i <= addr;
    cpu_we_i  <= 1'b1;
    cpu_req_i <= 1'b0;
    @(posedge clk);
    cpu_we_i        <= 1'b0;
    cpu_adr_match_i <= addr;
    cpu_dat_i       <= data;
    cpu_bsel_i      <= bsel;
    cpu_req_i       <= 1'b1;
    do @(negedge clk); while (!cpu_ack_o);
    @(posedge clk);
    cpu_req_i <= 1'b0;
  endtask

  // Strobe held until the ack while the data carries the line address
  task automatic invalidate_line(input logic [15:0] spr_addr, input dcache_pkg::word_t addr);
    @(posedge clk);
    spr_bus_addr_i <= spr_addr;
    spr_bus_dat_i  <= addr;
    spr_bus_we_i   <= 1'b1;
    spr_bus_stb_i  <= 1'b1;
    do @(negedge clk); while (!spr_bus_ack_o);
    @(posedge clk);
    spr_bus_stb_i <= 1'b0;
    spr_bus_we_i  <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    dcache_pkg::word_t wr_addr;
    dcache_pkg::word_t wr_data;
    seed            = 48;
    key             = $random(seed);
    rst             = 1'b1;
    cpu_adr_i       = '0;
    cpu_adr_match_i = '0;
    cpu_req_i       = 1'b0;
    cpu_we_i        = 1'b0;
    cpu_dat_i       = '0;
    cpu_bsel_i      = '0;
    wradr_i         = '0;
    wrdat_i         = '0;
    we_i            = 1'b0;
    dbus_err_i      = 1'b0;
    spr_bus_addr_i  = '0;
    spr_bus_we_i    = 1'b0;
    spr_bus_stb_i   = 1'b0;
    spr_bus_dat_i   = '0;

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle_outputs("first idle cycle");

    // Cold miss fills line L and then every word of it hits
    read_and_compare(LINE_L, 1'b1);
    for (int i = 0; i < `DC_LINE_WORDS; i++) begin
      read_and_compare(LINE_L + 4 * i, 1'b0);
    end

    // Bytes 0 and 2 replaced and memory follows since the cache writes through
    wr_addr = LINE_L + 32'h0C;
    wr_data = 32'hA1B2_C3D4;
    write_bytes(wr_addr, wr_data, 4'b0101);
    written[wr_addr] = (wr_data & 32'h00FF_00FF) | (model_word(wr_addr) & 32'hFF00_FF00);
    read_and_compare(wr_addr, 1'b0);

    // A and B fill both ways and touching A leaves B as victim
    read_and_compare(LINE_A, 1'b1);
    read_and_compare(LINE_B + 4, 1'b1);
    read_and_compare(LINE_A + 8, 1'b0);
    read_and_compare(LINE_C + 12, 1'b1);
    read_and_compare(LINE_A + 16, 1'b0);
    read_and_compare(LINE_B + 20, 1'b1);

    // Both SPR addresses drop the line
    invalidate_line(`DC_SPR_DCBIR_ADDR, LINE_A);
    read_and_compare(LINE_A, 1'b1);
    invalidate_line(`DC_SPR_DCBFR_ADDR, LINE_A);
    read_and_compare(LINE_A + 4, 1'b1);
    // Merged word comes back from memory
    invalidate_line(`DC_SPR_DCBIR_ADDR, LINE_L);
    read_and_compare(wr_addr, 1'b1);

    repeat (2) @(posedge clk);
    if (!failed) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_if.sv
verilog/dcache_dpram.sv
verilog/dcache_lru.sv
verilog/dcache_tag_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/tb_dcache.sv

/* Makefile */
# Verilator build and run of the data cache testbench

TOP := tb_dcache
SIM := obj_dir/V$(TOP)

.PHONY: all lint clean

# Build, run, and pass only when the pass line shows up in the output
all: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

$(SIM): compile.f $(wildcard verilog/*.sv verilog/*.svh test/*.sv)
	verilator --binary --assert -j 0 -f compile.f --top-module $(TOP)

# Lint the RTL top level
lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module dcache_top

clean:
	rm -rf obj_dir
